/* hdl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regaddr_t;

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0D,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // Function codes used under OP_SPECIAL
  typedef enum logic [5:0] {
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A
  } funct_t;

  typedef struct packed {
    opcode_t  opcode;
    regaddr_t rs;
    regaddr_t rt;
    regaddr_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t  opcode;
    regaddr_t rs;
    regaddr_t rt;
    logic [15:0] imm;
  } i_fmt_t;

  // One instruction word, read as register or immediate format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

  // Memory keeps words with the byte order reversed
  function automatic word_t swap_bytes(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

`default_nettype wire

/* hdl/mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

  // Multicycle sequence, one instruction at a time
  typedef enum logic [2:0] {
    FETCH  = 3'd0,
    DECODE = 3'd1,
    EXEC   = 3'd2,
    MEM    = 3'd3,
    WB     = 3'd4,
    HALT   = 3'd5
  } state_t;

  // Destination and source of the register write
  typedef enum logic [1:0] {
    WB_NONE    = 2'd0,
    WB_ALU_RD  = 2'd1,
    WB_ALU_RT  = 2'd2,
    WB_LOAD_RT = 2'd3
  } wb_sel_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_t;

endpackage

`default_nettype wire

/* hdl/mips_decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mips_decode_if
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
;

  regaddr_t    rs;
  regaddr_t    rt;
  regaddr_t    rd;
  word_t       imm;
  logic [25:0] target;
  alu_op_t     alu_op;
  logic        alu_src_imm;
  wb_sel_t     wb_sel;
  logic        is_load;
  logic        is_store;
  logic        is_branch_eq;
  logic        is_branch_ne;
  logic        is_jump;
  logic        is_jr;

  modport decode (
    output rs, rt, rd, imm, target, alu_op, alu_src_imm, wb_sel,
    output is_load, is_store, is_branch_eq, is_branch_ne, is_jump, is_jr
  );

  modport execute (
    input rs, rt, rd, imm, target, alu_op, alu_src_imm, wb_sel,
    input is_load, is_store, is_branch_eq, is_branch_ne, is_jump, is_jr
  );

  modport result (
    input rs, rt, rd, wb_sel, is_load
  );

endinterface

`default_nettype wire

/* hdl/mips_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_fsm
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
#(
  parameter word_t RESET_VECTOR = 32'hBFC00000
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   waitrequest_i,
  input  word_t  next_pc_i,
  mips_decode_if.execute dec,
  output state_t state_o,
  output word_t  pc_o,
  output logic   read_o,
  output logic   write_o,
  output logic   addr_sel_o
);

  state_t state_q;
  state_t state_d;
  word_t  pc_q;
  logic   read_q;
  logic   write_q;
  logic   bus_done;

  // An access completes in the cycle waitrequest is low
  assign bus_done = (read_q || write_q) && !waitrequest_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        if (bus_done) begin
          state_d = DECODE;
        end
      end
      DECODE: state_d = EXEC;
      EXEC: begin
        // A jump to address zero ends the program
        if (next_pc_i == '0) begin
          state_d = HALT;
        end else if (dec.is_load || dec.is_store) begin
          state_d = MEM;
        end else if (dec.wb_sel != WB_NONE) begin
          state_d = WB;
        end else begin
          state_d = FETCH;
        end
      end
      MEM: begin
        if (bus_done) begin
          state_d = (dec.wb_sel != WB_NONE) ? WB : FETCH;
        end
      end
      WB:      state_d = FETCH;
      HALT:    state_d = HALT;
      default: state_d = HALT;
    endcase
  end

  // Bus strobes come from the next state so they are up on the first cycle of an access
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= FETCH;
      pc_q    <= RESET_VECTOR;
      read_q  <= 1'b0;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == EXEC) begin
        pc_q <= next_pc_i;
      end
      read_q  <= (state_d == FETCH) || ((state_d == MEM) && dec.is_load);
      write_q <= (state_d == MEM) && dec.is_store;
    end
  end

  assign state_o    = state_q;
  assign pc_o       = pc_q;
  assign read_o     = read_q;
  assign write_o    = write_q;
  assign addr_sel_o = (state_q == MEM);

endmodule

`default_nettype wire

/* hdl/mips_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decode
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  state_t state_i,
  input  word_t  readdata_i,
  mips_decode_if.decode dec
);

  instr_t instr_q;

  // The last FETCH cycle is the one where the read completes
  always_ff @(posedge clk) begin
    if (reset) begin
      instr_q <= '0;
    end else if (state_i == FETCH) begin
      instr_q <= swap_bytes(readdata_i);
    end
  end

  always_comb begin
    dec.rs     = instr_q.r.rs;
    dec.rt     = instr_q.r.rt;
    dec.rd     = instr_q.r.rd;
    dec.target = instr_q[25:0];

    // ORI is the only zero-extended immediate
    if (instr_q.i.opcode == OP_ORI) begin
      dec.imm = {16'h0000, instr_q.i.imm};
    end else begin
      dec.imm = {{16{instr_q.i.imm[15]}}, instr_q.i.imm};
    end

    dec.alu_op       = ALU_ADD;
    dec.alu_src_imm  = 1'b0;
    dec.wb_sel       = WB_NONE;
    dec.is_load      = 1'b0;
    dec.is_store     = 1'b0;
    dec.is_branch_eq = 1'b0;
    dec.is_branch_ne = 1'b0;
    dec.is_jump      = 1'b0;
    dec.is_jr        = 1'b0;

    case (instr_q.i.opcode)
      OP_SPECIAL: begin
        dec.wb_sel = WB_ALU_RD;
        case (instr_q.r.funct)
          FN_ADDU: dec.alu_op = ALU_ADD;
          FN_SUBU: dec.alu_op = ALU_SUB;
          FN_AND:  dec.alu_op = ALU_AND;
          FN_OR:   dec.alu_op = ALU_OR;
          FN_XOR:  dec.alu_op = ALU_XOR;
          FN_SLT:  dec.alu_op = ALU_SLT;
          FN_JR: begin
            dec.is_jr  = 1'b1;
            dec.wb_sel = WB_NONE;
          end
          default: dec.wb_sel = WB_NONE;
        endcase
      end
      OP_J:   dec.is_jump = 1'b1;
      OP_BEQ: dec.is_branch_eq = 1'b1;
      OP_BNE: dec.is_branch_ne = 1'b1;
      OP_ADDIU: begin
        dec.alu_src_imm = 1'b1;
        dec.wb_sel      = WB_ALU_RT;
      end
      OP_ORI: begin
        dec.alu_op      = ALU_OR;
        dec.alu_src_imm = 1'b1;
        dec.wb_sel      = WB_ALU_RT;
      end
      OP_LW: begin
        dec.alu_src_imm = 1'b1;
        dec.is_load     = 1'b1;
        dec.wb_sel      = WB_LOAD_RT;
      end
      OP_SW: begin
        dec.alu_src_imm = 1'b1;
        dec.is_store    = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mips_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_execute
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  state_t state_i,
  input  word_t  pc_i,
  input  word_t  rs_data_i,
  input  word_t  rt_data_i,
  mips_decode_if.execute dec,
  output word_t  alu_result_o,
  output word_t  next_pc_o,
  output word_t  eff_addr_o,
  output word_t  writedata_o
);

  word_t operand_b;
  word_t alu_d;
  word_t alu_q;
  word_t store_q;
  word_t pc_plus4;
  word_t branch_target;
  word_t jump_target;
  logic  rs_eq_rt;
  logic  branch_taken;

  assign operand_b = dec.alu_src_imm ? dec.imm : rt_data_i;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD: alu_d = rs_data_i + operand_b;
      ALU_SUB: alu_d = rs_data_i - operand_b;
      ALU_AND: alu_d = rs_data_i & operand_b;
      ALU_OR:  alu_d = rs_data_i | operand_b;
      ALU_XOR: alu_d = rs_data_i ^ operand_b;
      ALU_SLT: alu_d = {31'd0, $signed(rs_data_i) < $signed(operand_b)};
      default: alu_d = '0;
    endcase
  end

  // No delay slot, so a taken branch goes straight to its target
  assign pc_plus4      = pc_i + 32'd4;
  assign branch_target = pc_plus4 + {dec.imm[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], dec.target, 2'b00};
  assign rs_eq_rt      = (rs_data_i == rt_data_i);
  assign branch_taken  = (dec.is_branch_eq && rs_eq_rt) || (dec.is_branch_ne && !rs_eq_rt);

  always_comb begin
    if (dec.is_jr) begin
      next_pc_o = rs_data_i;
    end else if (dec.is_jump) begin
      next_pc_o = jump_target;
    end else if (branch_taken) begin
      next_pc_o = branch_target;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

  // Hold the result and the store word steady through MEM and WB
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_q   <= '0;
      store_q <= '0;
    end else if (state_i == EXEC) begin
      alu_q   <= alu_d;
      store_q <= rt_data_i;
    end
  end

  assign alu_result_o = alu_q;
  // Loads and stores form their address with the ALU add
  assign eff_addr_o   = alu_q;
  assign writedata_o  = swap_bytes(store_q);

endmodule

`default_nettype wire

/* hdl/mips_result.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_result
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  state_t state_i,
  input  logic   waitrequest_i,
  input  word_t  readdata_i,
  input  word_t  alu_result_i,
  mips_decode_if.result dec,
  output word_t  rs_data_o,
  output word_t  rt_data_o,
  output word_t  register_v0_o
);

  word_t    regs [32];
  word_t    load_q;
  regaddr_t wr_addr;
  word_t    wr_data;
  logic     wr_en;

  // Register 0 always reads as zero
  assign rs_data_o = (dec.rs == '0) ? '0 : regs[dec.rs];
  assign rt_data_o = (dec.rt == '0) ? '0 : regs[dec.rt];

  assign wr_en   = (state_i == WB) && (dec.wb_sel != WB_NONE);
  assign wr_addr = (dec.wb_sel == WB_ALU_RD) ? dec.rd : dec.rt;
  assign wr_data = (dec.wb_sel == WB_LOAD_RT) ? load_q : alu_result_i;

  // Load data is only valid in the cycle the read completes
  always_ff @(posedge clk) begin
    if ((state_i == MEM) && dec.is_load && !waitrequest_i) begin
      load_q <= swap_bytes(readdata_i);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign register_v0_o = regs[2];

endmodule

`default_nettype wire

/* hdl/mips_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus
  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;
#(
  parameter word_t RESET_VECTOR = 32'hBFC00000
) (
  input  logic        clk,
  input  logic        reset,
  output logic        active_o,
  output logic [31:0] register_v0_o,
  output logic [31:0] address_o,
  output logic        write_o,
  output logic        read_o,
  input  logic        waitrequest_i,
  output logic [31:0] writedata_o,
  output logic [3:0]  byteenable_o,
  input  logic [31:0] readdata_i
);

  state_t state;
  word_t  pc;
  word_t  next_pc;
  word_t  alu_result;
  word_t  eff_addr;
  word_t  rs_data;
  word_t  rt_data;
  logic   addr_sel;

  mips_decode_if dec_if ();

  mips_fsm #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_fsm (
    .clk          (clk),
    .reset        (reset),
    .waitrequest_i(waitrequest_i),
    .next_pc_i    (next_pc),
    .dec          (dec_if),
    .state_o      (state),
    .pc_o         (pc),
    .read_o       (read_o),
    .write_o      (write_o),
    .addr_sel_o   (addr_sel)
  );

  mips_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .state_i   (state),
    .readdata_i(readdata_i),
    .dec       (dec_if)
  );

  mips_execute u_execute (
    .clk         (clk),
    .reset       (reset),
    .state_i     (state),
    .pc_i        (pc),
    .rs_data_i   (rs_data),
    .rt_data_i   (rt_data),
    .dec         (dec_if),
    .alu_result_o(alu_result),
    .next_pc_o   (next_pc),
    .eff_addr_o  (eff_addr),
    .writedata_o (writedata_o)
  );

  mips_result u_result (
    .clk          (clk),
    .reset        (reset),
    .state_i      (state),
    .waitrequest_i(waitrequest_i),
    .readdata_i   (readdata_i),
    .alu_result_i (alu_result),
    .dec          (dec_if),
    .rs_data_o    (rs_data),
    .rt_data_o    (rt_data),
    .register_v0_o(register_v0_o)
  );

  // Every access is a full word
  assign byteenable_o = 4'b1111;
  assign active_o     = (state != HALT);
  assign address_o    = addr_sel ? eff_addr : pc;

endmodule

`default_nettype wire

/* dv/mips_cpu_bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_checker (
  input logic        clk,
  input logic        reset,
  input logic        active_i,
  input logic        read_i,
  input logic        write_i,
  input logic        waitrequest_i,
  input logic [31:0] address_i,
  input logic [31:0] writedata_i
);

  // Only one kind of access at a time
  no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(read_i && write_i))
    else $error("read and write are high in the same cycle");

  // A stalled access keeps its strobe, address and data
  hold_on_wait: assert property (@(posedge clk) disable iff (reset)
    ((read_i || write_i) && waitrequest_i) |=>
      ($stable(read_i) && $stable(write_i) && $stable(address_i) && $stable(writedata_i)))
    else $error("access changed while waitrequest was high");

  // Halt is permanent until the next reset
  stay_halted: assert property (@(posedge clk) disable iff (reset)
    !active_i |=> !active_i)
    else $error("active rose again after the core halted");

  bus_idle_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> (!read_i && !write_i))
    else $error("bus strobe high in the first cycle after reset");

endmodule

bind mips_cpu_bus mips_cpu_bus_checker u_checker (
  .clk          (clk),
  .reset        (reset),
  .active_i     (active_o),
  .read_i       (read_o),
  .write_i      (write_o),
  .waitrequest_i(waitrequest_i),
  .address_i    (address_o),
  .writedata_i  (writedata_o)
);

`default_nettype wire

/* dv/mips_cpu_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_tb
  import mips_isa_pkg::*;
;

  localparam word_t RESET_VECTOR   = 32'hBFC0_0000;
  localparam int    TIMEOUT_CYCLES = 2000;

  // MIPS32 encodings of the subset
  localparam int SPECIAL_OPC = 'h00;
  localparam int J_OPC       = 'h02;
  localparam int BEQ_OPC     = 'h04;
  localparam int BNE_OPC     = 'h05;
  localparam int ADDIU_OPC   = 'h09;
  localparam int ORI_OPC     = 'h0D;
  localparam int LW_OPC      = 'h23;
  localparam int SW_OPC      = 'h2B;
  localparam int JR_FN       = 'h08;
  localparam int ADDU_FN     = 'h21;
  localparam int SUBU_FN     = 'h23;
  localparam int AND_FN      = 'h24;
  localparam int OR_FN       = 'h25;
  localparam int XOR_FN      = 'h26;
  localparam int SLT_FN      = 'h2A;

  logic        clk;
  logic        reset;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] address;
  logic        write;
  logic        read;
  logic        waitrequest = 1'b0;
  logic [31:0] writedata;
  logic [3:0]  byteenable;
  logic [31:0] readdata = '0;

  // Memory image in bus byte order, keyed by byte address
  word_t mem [word_t];
  word_t asm_pc;
  word_t wr_addr_log [$];
  word_t wr_data_log [$];
  bit    stall_en;
  int    stall_count = 0;
  string test_name;

  mips_cpu_bus #(
    .RESET_VECTOR(RESET_VECTOR)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .active_o     (active),
    .register_v0_o(register_v0),
    .address_o    (address),
    .write_o      (write),
    .read_o       (read),
    .waitrequest_i(waitrequest),
    .writedata_o  (writedata),
    .byteenable_o (byteenable),
    .readdata_i   (readdata)
  );

  always #2 clk = ~clk;

  task automatic report_failure();
    $display("*** FAILED ***");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    assert (actual === expected) else begin
      $display("Mismatch in %s (%s): expected %h, actual %h", test_name, what, expected, actual);
      report_failure();
    end
  endtask

  function automatic word_t byte_reverse(input word_t w);
    word_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  // Unwritten locations return a pattern built from the address
  function automatic word_t read_word(input word_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'hA5C3_5A3C;
  endfunction

  function automatic word_t insn_addr(input int idx);
    return RESET_VECTOR + word_t'(4 * idx);
  endfunction

  // Avalon slave, answers on the falling edge with optional stalls
  always @(negedge clk) begin
    if (read || write) begin
      if (stall_en && ($urandom % 3 == 0)) begin
        waitrequest = 1'b1;
        stall_count++;
      end else begin
        waitrequest = 1'b0;
        if (read) begin
          readdata = read_word(address);
        end
        if (write) begin
          assert (byteenable === 4'hF) else begin
            $display("Mismatch in %s (byteenable): expected f, actual %h", test_name, byteenable);
            report_failure();
          end
          mem[address] = writedata;
          wr_addr_log.push_back(address);
          wr_data_log.push_back(writedata);
        end
      end
    end else begin
      waitrequest = 1'b0;
    end
  end

  task automatic emit(input word_t instr);
    mem[asm_pc] = byte_reverse(instr);
    asm_pc += 4;
  endtask

  task automatic emit_r(input int funct, input int rd, input int rs, input int rt);
    emit({SPECIAL_OPC[5:0], rs[4:0], rt[4:0], rd[4:0], 5'd0, funct[5:0]});
  endtask

  task automatic emit_i(input int opc, input int rt, input int rs, input int imm);
    emit({opc[5:0], rs[4:0], rt[4:0], imm[15:0]});
  endtask

  task automatic emit_j(input word_t dest);
    emit({J_OPC[5:0], dest[27:2]});
  endtask

  task automatic prepare_program(input string name, input bit stall);
    test_name = name;
    stall_en  = stall;
    asm_pc    = RESET_VECTOR;
    mem.delete();
    wr_addr_log.delete();
    wr_data_log.delete();
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_program();
    int cycles;
    int stalls_before;
    apply_reset();
    stalls_before = stall_count;
    cycles = 0;
    while (active === 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: %s did not halt within %0d cycles", test_name, TIMEOUT_CYCLES);
        report_failure();
      end
    end
    if (stall_en) begin
      assert (stall_count > stalls_before) else begin
        $display("No waitrequest stall was inserted during %s", test_name);
        report_failure();
      end
    end
  endtask

  task automatic reset_test();
    int cycles;
    prepare_program("reset", 1'b0);
    emit_r(JR_FN, 0, 0, 0);
    @(negedge clk);
    reset = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_word("read in reset", 32'd0, word_t'(read));
      check_word("write in reset", 32'd0, word_t'(write));
      check_word("active in reset", 32'd1, word_t'(active));
    end
    reset = 1'b0;
    cycles = 0;
    while (read !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: no instruction fetch after reset");
        report_failure();
      end
    end
    check_word("first fetch address", RESET_VECTOR, address);
  endtask

  task automatic arith_test(input bit stall);
    word_t a;
    word_t b;
    word_t c;
    word_t r11;
    word_t r12;
    word_t r13;
    word_t r14;
    word_t r15;
    word_t r16;
    word_t r17;
    word_t expected;
    prepare_program(stall ? "arith_stall" : "arith", stall);
    emit_i(ADDIU_OPC, 8, 0, 'h1234);
    emit_i(ADDIU_OPC, 9, 0, -5);
    emit_i(ORI_OPC, 10, 0, 'h8001);
    emit_r(ADDU_FN, 11, 8, 9);
    emit_r(SUBU_FN, 12, 8, 10);
    emit_r(AND_FN, 13, 9, 10);
    emit_r(OR_FN, 14, 8, 10);
    emit_r(XOR_FN, 15, 11, 12);
    emit_r(SLT_FN, 16, 9, 8);
    emit_r(SLT_FN, 17, 8, 9);
    // Register 0 must ignore this write
    emit_i(ADDIU_OPC, 0, 0, 'h55);
    emit_r(ADDU_FN, 2, 11, 12);
    emit_r(XOR_FN, 2, 2, 13);
    emit_r(ADDU_FN, 2, 2, 14);
    emit_r(SUBU_FN, 2, 2, 15);
    emit_r(ADDU_FN, 2, 2, 16);
    emit_r(ADDU_FN, 2, 2, 16);
    emit_r(ADDU_FN, 2, 2, 17);
    emit_r(ADDU_FN, 2, 2, 0);
    emit_r(JR_FN, 0, 0, 0);
    run_program();

    a = 32'h0000_1234;
    b = 32'hFFFF_FFFB;  // -5 after sign extension
    c = 32'h0000_8001;  // ORI zero-extends
    r11 = a + b;
    r12 = a - c;
    r13 = b & c;
    r14 = a | c;
    r15 = r11 ^ r12;
    r16 = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    r17 = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    expected = (((r11 + r12) ^ r13) + r14) - r15 + r16 + r16 + r17;
    check_word("v0", expected, register_v0);
    check_word("write count", 32'd0, word_t'(wr_addr_log.size()));
  endtask

  task automatic load_store_test(input bit stall);
    prepare_program(stall ? "load_store_stall" : "load_store", stall);
    mem[32'h0000_2000] = byte_reverse(32'h1357_9BDF);
    emit_i(ORI_OPC, 8, 0, 'h1000);
    emit_i(ADDIU_OPC, 9, 0, 'h89AB);
    emit_i(SW_OPC, 9, 8, 8);
    emit_i(LW_OPC, 10, 0, 'h2000);
    emit_i(SW_OPC, 10, 8, 'h10);
    emit_i(LW_OPC, 2, 8, 8);
    emit_r(JR_FN, 0, 0, 0);
    run_program();

    check_word("v0", 32'hFFFF_89AB, register_v0);
    check_word("write count", 32'd2, word_t'(wr_addr_log.size()));
    check_word("first write address", 32'h0000_1008, wr_addr_log[0]);
    check_word("first write data", byte_reverse(32'hFFFF_89AB), wr_data_log[0]);
    check_word("second write address", 32'h0000_1010, wr_addr_log[1]);
    check_word("second write data", byte_reverse(32'h1357_9BDF), wr_data_log[1]);
  endtask

  task automatic control_flow_test();
    word_t expected;
    prepare_program("control_flow", 1'b0);
    emit_i(ADDIU_OPC, 8, 0, 5);
    emit_i(ADDIU_OPC, 9, 0, 5);
    emit_i(ADDIU_OPC, 10, 0, 7);
    emit_i(BEQ_OPC, 9, 8, 1);        // taken
    emit_i(ADDIU_OPC, 2, 2, 'h100);
    emit_i(ADDIU_OPC, 2, 2, 1);
    emit_i(BEQ_OPC, 10, 8, 1);       // not taken
    emit_i(ADDIU_OPC, 2, 2, 2);
    emit_i(BNE_OPC, 10, 8, 1);       // taken
    emit_i(ADDIU_OPC, 2, 2, 'h200);
    emit_i(ADDIU_OPC, 2, 2, 4);
    emit_i(BNE_OPC, 9, 8, 1);        // not taken
    emit_i(ADDIU_OPC, 2, 2, 8);
    emit_j(insn_addr(15));
    emit_i(ADDIU_OPC, 2, 2, 'h400);
    emit_i(ADDIU_OPC, 2, 2, 16);
    emit_r(JR_FN, 0, 0, 0);
    run_program();

    // Words after a taken branch or jump never run
    expected = 32'd1 + 32'd2 + 32'd4 + 32'd8 + 32'd16;
    check_word("v0", expected, register_v0);
  endtask

  initial begin
    void'($urandom(32'h76199bd6));
    clk      = 1'b0;
    reset    = 1'b1;
    stall_en = 1'b0;
    reset_test();
    arith_test(1'b0);
    load_store_test(1'b0);
    control_flow_test();
    arith_test(1'b1);
    load_store_test(1'b1);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* mips_cpu_bus.f */
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/mips_decode_if.sv
hdl/mips_fsm.sv
hdl/mips_decode.sv
hdl/mips_execute.sv
hdl/mips_result.sv
hdl/mips_cpu_bus.sv
dv/mips_cpu_bus_checker.sv
dv/mips_cpu_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module mips_cpu_bus_tb -f mips_cpu_bus.f \
  && ./obj_dir/Vmips_cpu_bus_tb \
  || { echo "Simulation did not pass"; exit 1; }
